// File: arp_resp.f
verilog/arp_pkg.sv
verilog/arp_rx_if.sv
verilog/arp_rx_parse.sv
verilog/arp_reply_ctrl.sv
verilog/arp_tx_build.sv
verilog/arp_resp_top.sv
testbench/arp_resp_checker.sv
testbench/arp_resp_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ARP responder testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  -f arp_resp.f \
  --top-module arp_resp_tb \
  -o arp_resp_sim

./obj_dir/arp_resp_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"

// File: testbench/arp_resp_checker.sv
`timescale 1ns/1ns

module arp_resp_checker #(
  parameter int CACHE_DEPTH = 4
) (
  input  logic               clk,
  input  logic               fsm_rst,
  input  arp_pkg::mac_addr_t dev_mac,
  input  arp_pkg::ipv4_t     dev_ipv4,
  input  logic               tx_val,
  input  logic [7:0]         tx_dat,
  input  logic               tx_last,
  input  arp_pkg::ipv4_t     lookup_ipv4,
  input  logic               lookup_hit,
  input  arp_pkg::mac_addr_t lookup_mac,
  input  logic               frame_stb,
  input  logic [15:0]        f_ethertype,
  input  logic [15:0]        f_oper,
  input  logic [47:0]        f_sha,
  input  logic [31:0]        f_spa,
  input  logic [31:0]        f_tpa,
  input  int                 f_len,
  input  int                 f_err_idx,
  input  logic               look_stb,
  input  logic               look_hit_exp,
  input  logic [47:0]        look_mac_exp,
  output logic               busy,
  output int                 err_cnt
);

  import arp_pkg::*;

  logic [31:0] m_ip  [CACHE_DEPTH];
  logic [47:0] m_mac [CACHE_DEPTH];
  logic        m_vld [CACHE_DEPTH];
  int          m_ptr;
  logic [7:0]  exp_bytes [ARP_HDR_LEN];
  logic        exp_reply;
  int          wait_cnt;
  int          byte_idx;
  int          settle;

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic learn_sender();
    int found;
    found = -1;
    for (int i = 0; i < CACHE_DEPTH; i++) begin
      if (m_vld[i] && m_ip[i] == f_spa) found = i;
    end
    if (found >= 0) begin
      m_mac[found] = f_sha; // known sender, new mac.
    end
    else begin
      m_ip[m_ptr]  = f_spa;
      m_mac[m_ptr] = f_sha;
      m_vld[m_ptr] = 1'b1;
      m_ptr = (m_ptr + 1) % CACHE_DEPTH;
    end
  endtask

  task automatic predict_frame();
    logic good;
    good = f_ethertype == 16'h0806 && f_len == ARP_PAYLOAD_LEN && f_err_idx == 0;
    settle = 4;
    busy = 1'b1;
    if (good) learn_sender();
    if (good && f_oper == 16'h0001 && f_tpa == dev_ipv4) begin
      exp_bytes[0] = 8'h00;
      exp_bytes[1] = 8'h01;
      exp_bytes[2] = 8'h08;
      exp_bytes[3] = 8'h00;
      exp_bytes[4] = 8'h06;
      exp_bytes[5] = 8'h04;
      exp_bytes[6] = 8'h00;
      exp_bytes[7] = 8'h02;
      for (int k = 0; k < 6; k++) begin
        exp_bytes[8 + k]  = dev_mac[5 - k];
        exp_bytes[18 + k] = f_sha[8 * (5 - k) +: 8];
      end
      for (int k = 0; k < 4; k++) begin
        exp_bytes[14 + k] = dev_ipv4[3 - k];
        exp_bytes[24 + k] = f_spa[8 * (3 - k) +: 8];
      end
      exp_reply = 1'b1;
      wait_cnt = 3; // first byte three edges after the last rx byte.
      byte_idx = 0;
    end
  endtask

  task automatic check_lookup();
    logic        m_hit;
    logic [47:0] m_res;
    m_hit = 1'b0;
    m_res = '0;
    for (int i = 0; i < CACHE_DEPTH; i++) begin
      if (m_vld[i] && m_ip[i] == lookup_ipv4) begin
        m_hit = 1'b1;
        m_res = m_mac[i];
      end
    end
    if (m_hit !== look_hit_exp || (m_hit && m_res !== look_mac_exp))
      report_mismatch($sformatf("cache model disagrees with vector for %h", lookup_ipv4));
    if (lookup_hit !== look_hit_exp)
      report_mismatch($sformatf("lookup %h hit %b, expected %b", lookup_ipv4,
                                lookup_hit, look_hit_exp));
    else if (look_hit_exp && lookup_mac !== look_mac_exp)
      report_mismatch($sformatf("lookup %h mac %h, expected %h", lookup_ipv4,
                                lookup_mac, look_mac_exp));
  endtask

  initial err_cnt = 0;

  always @(posedge clk) begin
    if (fsm_rst) begin
      for (int i = 0; i < CACHE_DEPTH; i++) m_vld[i] = 1'b0;
      m_ptr = 0;
      exp_reply = 1'b0;
      busy = 1'b0;
      settle = 0;
    end
    else begin
      if (exp_reply) begin
        if (wait_cnt > 0) begin
          if (tx_val || tx_last) report_mismatch("tx output active before reply time");
          wait_cnt--;
        end
        else if (!tx_val) begin
          if (wait_cnt == 0)
            report_mismatch($sformatf("tx_val low at reply byte %0d", byte_idx));
          wait_cnt = -1; // late or cut short, keep waiting.
        end
        else begin
          if (tx_dat !== exp_bytes[byte_idx])
            report_mismatch($sformatf("reply byte %0d is %h, expected %h", byte_idx,
                                      tx_dat, exp_bytes[byte_idx]));
          if (tx_last !== (byte_idx == ARP_HDR_LEN - 1))
            report_mismatch($sformatf("tx_last wrong at reply byte %0d", byte_idx));
          byte_idx++;
          if (byte_idx == ARP_HDR_LEN) begin
            exp_reply = 1'b0;
            busy = 1'b0;
          end
        end
      end
      else begin
        if (tx_val || tx_last) report_mismatch("tx output active with no reply expected");
        if (settle > 0) begin
          settle--;
          if (settle == 0) busy = 1'b0;
        end
      end
      if (frame_stb) predict_frame();
      if (look_stb) check_lookup();
    end
  end

endmodule

// File: testbench/arp_resp_tb.sv
`timescale 1ns/1ns

module arp_resp_tb;

  import arp_pkg::*;

  logic        clk;
  logic        fsm_rst;
  mac_addr_t   dev_mac;
  ipv4_t       dev_ipv4;
  logic        rx_val;
  logic [7:0]  rx_dat;
  logic        rx_last;
  logic        rx_err;
  logic [15:0] rx_ethertype;
  ipv4_t       lookup_ipv4;
  logic        tx_val;
  logic [7:0]  tx_dat;
  logic        tx_last;
  logic        lookup_hit;
  mac_addr_t   lookup_mac;

  logic        frame_stb;
  logic [15:0] f_ethertype;
  logic [15:0] f_oper;
  logic [47:0] f_sha;
  logic [31:0] f_spa;
  logic [31:0] f_tpa;
  int          f_len;
  int          f_err_idx;
  logic        look_stb;
  logic        look_hit_exp;
  logic [47:0] look_mac_exp;
  logic        busy;
  int          chk_errs;
  int          timeout_errs;
  logic [15:0] lfsr_state;

  int          fd;
  int          code;
  int          nfields;
  string       line;
  logic [7:0]  kind;
  logic [7:0]  gap;

  arp_resp_top #(.CACHE_DEPTH(4)) dut_i (
    .clk(clk), .fsm_rst(fsm_rst), .dev_mac(dev_mac), .dev_ipv4(dev_ipv4),
    .rx_val(rx_val), .rx_dat(rx_dat), .rx_last(rx_last), .rx_err(rx_err),
    .rx_ethertype(rx_ethertype), .lookup_ipv4(lookup_ipv4),
    .tx_val(tx_val), .tx_dat(tx_dat), .tx_last(tx_last),
    .lookup_hit(lookup_hit), .lookup_mac(lookup_mac)
  );

  arp_resp_checker #(.CACHE_DEPTH(4)) checker_i (
    .clk(clk), .fsm_rst(fsm_rst), .dev_mac(dev_mac), .dev_ipv4(dev_ipv4),
    .tx_val(tx_val), .tx_dat(tx_dat), .tx_last(tx_last),
    .lookup_ipv4(lookup_ipv4), .lookup_hit(lookup_hit), .lookup_mac(lookup_mac),
    .frame_stb(frame_stb), .f_ethertype(f_ethertype), .f_oper(f_oper),
    .f_sha(f_sha), .f_spa(f_spa), .f_tpa(f_tpa), .f_len(f_len),
    .f_err_idx(f_err_idx), .look_stb(look_stb), .look_hit_exp(look_hit_exp),
    .look_mac_exp(look_mac_exp), .busy(busy), .err_cnt(chk_errs)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[6:0], lfsr_state[0]};
    end
  endtask

  task automatic send_frame();
    logic [7:0] hb [ARP_HDR_LEN];
    logic [7:0] pad;
    int         waited;
    hb[0] = 8'h00;
    hb[1] = 8'h01;
    hb[2] = 8'h08;
    hb[3] = 8'h00;
    hb[4] = 8'h06;
    hb[5] = 8'h04;
    hb[6] = f_oper[15:8];
    hb[7] = f_oper[7:0];
    for (int k = 0; k < 6; k++) begin
      hb[8 + k]  = f_sha[8 * (5 - k) +: 8];
      hb[18 + k] = 8'h00; // tha unknown in a request.
    end
    for (int k = 0; k < 4; k++) begin
      hb[14 + k] = f_spa[8 * (3 - k) +: 8];
      hb[24 + k] = f_tpa[8 * (3 - k) +: 8];
    end
    for (int i = 0; i < f_len; i++) begin
      @(negedge clk);
      if (i >= ARP_HDR_LEN) take_bits(8, pad);
      rx_ethertype = f_ethertype;
      rx_val    = 1'b1;
      rx_dat    = (i < ARP_HDR_LEN) ? hb[i] : pad;
      rx_last   = (i == f_len - 1);
      rx_err    = (i + 1 == f_err_idx);
      frame_stb = (i == f_len - 1);
    end
    @(negedge clk);
    rx_val    = 1'b0;
    rx_last   = 1'b0;
    rx_err    = 1'b0;
    frame_stb = 1'b0;
    waited = 0;
    while (busy && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (busy) begin
      $display("ERROR at %0t: reply never arrived", $time);
      timeout_errs++;
    end
    take_bits(2, gap);
    for (int g = 0; g < gap && g < 200; g++) @(negedge clk); // idle gap.
  endtask

  task automatic do_lookup(input logic [31:0] ip, input logic hit, input logic [47:0] mac);
    @(negedge clk);
    lookup_ipv4  = ip;
    look_hit_exp = hit;
    look_mac_exp = mac;
    look_stb     = 1'b1;
    @(negedge clk);
    look_stb     = 1'b0;
  endtask

  initial begin
    fsm_rst = 1'b1;
    dev_mac = 48'h02_00_00_00_00_01;
    dev_ipv4 = 32'hc0_a8_00_01;
    rx_val = 1'b0;
    rx_dat = '0;
    rx_last = 1'b0;
    rx_err = 1'b0;
    rx_ethertype = '0;
    lookup_ipv4 = '0;
    frame_stb = 1'b0;
    f_ethertype = '0;
    f_oper = '0;
    f_sha = '0;
    f_spa = '0;
    f_tpa = '0;
    f_len = 0;
    f_err_idx = 0;
    look_stb = 1'b0;
    look_hit_exp = 1'b0;
    look_mac_exp = '0;
    timeout_errs = 0;
    lfsr_state = 16'd61;
    repeat (2) @(negedge clk);
    fsm_rst = 1'b0;
    fd = $fopen("testbench/arp_tests.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open testbench/arp_tests.txt");
      timeout_errs++;
    end
    else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 1 && line.substr(0, 0) == "F") begin
          nfields = $sscanf(line, "%c %h %h %h %h %h %d %d", kind, f_ethertype,
                            f_oper, f_sha, f_spa, f_tpa, f_len, f_err_idx);
          if (nfields == 8) begin
            send_frame();
          end
          else begin
            $display("ERROR: malformed frame line in test file");
            timeout_errs++;
          end
        end
        else if (code > 1 && line.substr(0, 0) == "L") begin
          nfields = $sscanf(line, "%c %h %h %h", kind, f_spa, look_hit_exp, f_sha);
          if (nfields == 4) begin
            do_lookup(f_spa, look_hit_exp, f_sha);
          end
          else begin
            $display("ERROR: malformed lookup line in test file");
            timeout_errs++;
          end
        end
      end
      $fclose(fd);
    end
    repeat (4) @(negedge clk);
    $display("errors: %0d check, %0d timeout", chk_errs, timeout_errs);
    if (chk_errs == 0 && timeout_errs == 0) begin
      $display("RESULT: PASS");
    end
    else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: testbench/arp_tests.txt
# F ethertype oper sha spa tpa length err_byte (hex, hex, hex, hex, hex, dec, dec)
# L ipv4 expected_hit expected_mac (hex)
L c0a80064 0 000000000000
F 0806 0001 0a0000000064 c0a80064 c0a80001 46 0
L c0a80064 1 0a0000000064
F 0806 0001 0a0000000065 c0a80065 c0a80002 46 0
F 0806 0002 0a0000000066 c0a80066 c0a80001 46 0
F 0800 0001 0a0000000070 c0a80070 c0a80001 46 0
L c0a80065 1 0a0000000065
L c0a80066 1 0a0000000066
L c0a80070 0 000000000000
F 0806 0001 0a0000000071 c0a80071 c0a80001 46 10
F 0806 0001 0a0000000072 c0a80072 c0a80001 40 0
F 0806 0001 0a0000000073 c0a80073 c0a80001 48 0
L c0a80071 0 000000000000
L c0a80072 0 000000000000
L c0a80073 0 000000000000
F 0806 0001 0b0000000064 c0a80064 c0a80001 46 0
L c0a80064 1 0b0000000064
F 0806 0002 0a0000000067 c0a80067 c0a80009 46 0
F 0806 0001 0a0000000068 c0a80068 c0a80001 46 0
L c0a80064 0 000000000000
L c0a80065 1 0a0000000065
L c0a80066 1 0a0000000066
L c0a80067 1 0a0000000067
L c0a80068 1 0a0000000068

// File: verilog/arp_pkg.sv
package arp_pkg;

  typedef logic [5:0][7:0] mac_addr_t; // byte 5 goes out first.
  typedef logic [3:0][7:0] ipv4_t;

  // header fields in wire order.
  typedef struct packed {
    logic [15:0] htype;
    logic [15:0] ptype;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    logic [15:0] oper;
    mac_addr_t   sha;
    ipv4_t       spa;
    mac_addr_t   tha;
    ipv4_t       tpa;
  } arp_hdr_t;

  // requester addresses for the reply.
  typedef struct packed {
    mac_addr_t tha;
    ipv4_t     tpa;
  } arp_reply_t;

  localparam logic [15:0] ETHERTYPE_ARP  = 16'h0806;
  localparam logic [15:0] ARP_HTYPE_ETH  = 16'h0001;
  localparam logic [15:0] ARP_PTYPE_IPV4 = 16'h0800;
  localparam logic [15:0] ARP_OPER_REQ   = 16'h0001;
  localparam logic [15:0] ARP_OPER_REPLY = 16'h0002;

  localparam int ARP_HDR_LEN     = 28;
  localparam int ARP_PAYLOAD_LEN = 46; // padded min ethernet payload.

endpackage

// File: verilog/arp_reply_ctrl.sv
`timescale 1ns/1ns

module arp_reply_ctrl #(
  parameter int CACHE_DEPTH = 4
) (
  input  logic                clk,
  input  logic                fsm_rst,
  input  arp_pkg::ipv4_t      dev_ipv4,
  input  arp_pkg::arp_hdr_t   hdr,
  input  logic                hdr_vld,
  input  arp_pkg::ipv4_t      lookup_ipv4,
  output logic                lookup_hit,
  output arp_pkg::mac_addr_t  lookup_mac,
  output arp_pkg::arp_reply_t reply,
  output logic                reply_start
);

  import arp_pkg::*;

  localparam int PTR_W = $clog2(CACHE_DEPTH);

  ipv4_t     cache_ip  [CACHE_DEPTH];
  mac_addr_t cache_mac [CACHE_DEPTH];
  logic [CACHE_DEPTH-1:0] cache_vld;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] spa_idx;
  logic [PTR_W-1:0] wr_idx;
  logic spa_known;
  logic hdr_ok;
  logic is_req;

  // ethernet/ipv4 only, address lengths 6 and 4.
  assign hdr_ok = hdr.htype == ARP_HTYPE_ETH && hdr.ptype == ARP_PTYPE_IPV4 &&
                  hdr.hlen == 8'd6 && hdr.plen == 8'd4;
  assign is_req = hdr_ok && hdr.oper == ARP_OPER_REQ && hdr.tpa == dev_ipv4;
  assign wr_idx = spa_known ? spa_idx : wr_ptr;

  always_comb begin
    spa_known = 1'b0;
    spa_idx   = '0;
    for (int i = 0; i < CACHE_DEPTH; i++) begin
      if (cache_vld[i] && cache_ip[i] == hdr.spa) begin
        spa_known = 1'b1;
        spa_idx   = PTR_W'(i);
      end
    end
  end

  always_comb begin
    lookup_hit = 1'b0;
    lookup_mac = '0;
    for (int i = 0; i < CACHE_DEPTH; i++) begin
      if (cache_vld[i] && cache_ip[i] == lookup_ipv4) begin
        lookup_hit = 1'b1;
        lookup_mac = cache_mac[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      cache_vld   <= '0;
      wr_ptr      <= '0;
      reply_start <= 1'b0;
    end
    else begin
      reply_start <= hdr_vld && is_req;
      if (hdr_vld && hdr_ok && !spa_known) begin
        cache_vld[wr_ptr] <= 1'b1; // new sender takes the oldest slot.
        wr_ptr <= (wr_ptr == PTR_W'(CACHE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_vld && hdr_ok) begin
      cache_ip[wr_idx]  <= hdr.spa;
      cache_mac[wr_idx] <= hdr.sha;
    end
    if (hdr_vld && is_req) begin
      reply.tha <= hdr.sha;
      reply.tpa <= hdr.spa;
    end
  end

endmodule

// File: verilog/arp_resp_top.sv
`timescale 1ns/1ns

module arp_resp_top #(
  parameter int CACHE_DEPTH = 4
) (
  input  logic               clk,
  input  logic               fsm_rst,
  input  arp_pkg::mac_addr_t dev_mac,
  input  arp_pkg::ipv4_t     dev_ipv4,
  input  logic               rx_val,
  input  logic [7:0]         rx_dat,
  input  logic               rx_last,
  input  logic               rx_err,
  input  logic [15:0]        rx_ethertype,
  input  arp_pkg::ipv4_t     lookup_ipv4,
  output logic               tx_val,
  output logic [7:0]         tx_dat,
  output logic               tx_last,
  output logic               lookup_hit,
  output arp_pkg::mac_addr_t lookup_mac
);

  import arp_pkg::*;

  arp_hdr_t   hdr;
  logic       hdr_vld;
  arp_reply_t reply;
  logic       reply_start;

  arp_rx_if rx_if ();

  assign rx_if.val       = rx_val;
  assign rx_if.dat       = rx_dat;
  assign rx_if.last      = rx_last;
  assign rx_if.err       = rx_err;
  assign rx_if.ethertype = rx_ethertype;

  arp_rx_parse parse_i (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .rx      (rx_if.snk),
    .hdr     (hdr),
    .hdr_vld (hdr_vld)
  );

  arp_reply_ctrl #(
    .CACHE_DEPTH (CACHE_DEPTH)
  ) ctrl_i (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .dev_ipv4    (dev_ipv4),
    .hdr         (hdr),
    .hdr_vld     (hdr_vld),
    .lookup_ipv4 (lookup_ipv4),
    .lookup_hit  (lookup_hit),
    .lookup_mac  (lookup_mac),
    .reply       (reply),
    .reply_start (reply_start)
  );

  arp_tx_build build_i (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .dev_mac     (dev_mac),
    .dev_ipv4    (dev_ipv4),
    .reply       (reply),
    .reply_start (reply_start),
    .tx_val      (tx_val),
    .tx_dat      (tx_dat),
    .tx_last     (tx_last)
  );

endmodule

// File: verilog/arp_rx_if.sv
`timescale 1ns/1ns

interface arp_rx_if;

  logic        val;
  logic [7:0]  dat;
  logic        last;
  logic        err;
  logic [15:0] ethertype; // stable over the frame.

  modport src (
    output val, dat, last, err, ethertype
  );

  modport snk (
    input val, dat, last, err, ethertype
  );

endinterface

// File: verilog/arp_rx_parse.sv
`timescale 1ns/1ns

module arp_rx_parse (
  input  logic              clk,
  input  logic              fsm_rst,
  arp_rx_if.snk             rx,
  output arp_pkg::arp_hdr_t hdr,
  output logic              hdr_vld
);

  import arp_pkg::*;

  localparam logic [5:0] LAST_IDX = 6'(ARP_PAYLOAD_LEN - 1);
  localparam logic [5:0] HDR_LEN  = 6'(ARP_HDR_LEN);

  logic [ARP_HDR_LEN-1:0][7:0] cur_hdr;
  logic [5:0] byte_cnt;
  logic drop;       // rest of frame is ignored.
  logic hdr_pend;
  logic take;
  logic frame_end;

  assign take      = rx.val && !rx.err && !drop && rx.ethertype == ETHERTYPE_ARP;
  assign frame_end = take && rx.last && byte_cnt == LAST_IDX;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      byte_cnt <= '0;
      drop     <= 1'b0;
      hdr_pend <= 1'b0;
      hdr_vld  <= 1'b0;
    end
    else begin
      hdr_pend <= frame_end;
      hdr_vld  <= hdr_pend;
      if (rx.err && (rx.val || byte_cnt != '0)) begin
        // corrupted frame, wait for its end.
        byte_cnt <= '0;
        drop     <= !(rx.val && rx.last);
      end
      else if (rx.val) begin
        if (rx.last) begin
          byte_cnt <= '0; // good, short or foreign frame ends here.
          drop     <= 1'b0;
        end
        else if (take) begin
          if (byte_cnt == LAST_IDX) begin
            byte_cnt <= '0; // too long.
            drop     <= 1'b1;
          end
          else begin
            byte_cnt <= byte_cnt + 6'd1;
          end
        end
      end
    end
  end

  // header shift register, padding bytes are not kept.
  always_ff @(posedge clk) begin
    if (take && byte_cnt < HDR_LEN) begin
      cur_hdr <= {cur_hdr[ARP_HDR_LEN-2:0], rx.dat};
    end
    if (frame_end) begin
      hdr <= cur_hdr;
    end
  end

endmodule

// File: verilog/arp_tx_build.sv
`timescale 1ns/1ns

module arp_tx_build (
  input  logic                clk,
  input  logic                fsm_rst,
  input  arp_pkg::mac_addr_t  dev_mac,
  input  arp_pkg::ipv4_t      dev_ipv4,
  input  arp_pkg::arp_reply_t reply,
  input  logic                reply_start,
  output logic                tx_val,
  output logic [7:0]          tx_dat,
  output logic                tx_last
);

  import arp_pkg::*;

  localparam logic [4:0] LAST_IDX = 5'(ARP_HDR_LEN - 1);

  arp_hdr_t rep_hdr;
  logic [ARP_HDR_LEN-1:0][7:0] tx_sr;
  logic [4:0] tx_cnt;

  always_comb begin
    rep_hdr.htype = ARP_HTYPE_ETH;
    rep_hdr.ptype = ARP_PTYPE_IPV4;
    rep_hdr.hlen  = 8'd6;
    rep_hdr.plen  = 8'd4;
    rep_hdr.oper  = ARP_OPER_REPLY;
    rep_hdr.sha   = dev_mac;
    rep_hdr.spa   = dev_ipv4;
    rep_hdr.tha   = reply.tha; // back to the requester.
    rep_hdr.tpa   = reply.tpa;
  end

  assign tx_dat  = tx_sr[ARP_HDR_LEN-1];
  assign tx_last = tx_val && tx_cnt == LAST_IDX;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tx_val <= 1'b0;
      tx_cnt <= '0;
    end
    else if (reply_start) begin
      tx_val <= 1'b1;
      tx_cnt <= '0;
    end
    else if (tx_val) begin
      tx_cnt <= tx_cnt + 5'd1;
      if (tx_cnt == LAST_IDX) begin
        tx_val <= 1'b0;
      end
    end
  end

  // msb byte is always the one on the wire.
  always_ff @(posedge clk) begin
    if (reply_start) begin
      tx_sr <= rep_hdr;
    end
    else if (tx_val) begin
      tx_sr <= {tx_sr[ARP_HDR_LEN-2:0], 8'h00};
    end
  end

endmodule
